// File: design/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

	// ==============================
	// Register opcodes
	// ==============================

	// Opcode is {cpu_addr[14], cpu_addr[13], cpu_addr[0]}
	typedef enum logic [2:0] {
		reg_bank_select = 3'd0, // $8000
		reg_bank_data   = 3'd1, // $8001
		reg_mirror      = 3'd2, // $A000
		reg_ram_cfg     = 3'd3, // $A001
		reg_irq_latch   = 3'd4, // $C000
		reg_irq_reload  = 3'd5, // $C001
		reg_irq_disable = 3'd6, // $E000
		reg_irq_enable  = 3'd7  // $E001
	} mmc_reg_e;

	// ==============================
	// Buses
	// ==============================

	typedef struct packed {
		logic swap_control; // PRG $8000/$C000 swap
		logic chr_invert;   // 2 KB CHR windows at $1000
		logic mirror_mode;  // 1 selects horizontal
		logic ram_on;
		logic ram_we_off;
	} mmc_cfg_t;

	typedef struct packed {
		logic       we;
		logic [2:0] sel;  // Target slot
		logic [7:0] data;
	} slot_wr_t;

	typedef struct packed {
		logic       hit;  // Window covers the current address
		logic [7:0] page;
	} slot_out_t;

	// Latch value itself travels on a separate bus
	typedef struct packed {
		logic latch_we;
		logic reload_req;
		logic disable_ack;
		logic enable;
	} irq_cmd_t;

	// ==============================
	// Constants
	// ==============================

	localparam int SLOT_COUNT = 8;
	localparam int CHR_SLOT_COUNT = 6; // Slots 0..5 are CHR, the rest PRG

	localparam logic [7:0] SLOT_RESET [SLOT_COUNT] = '{
		8'd0, 8'd2, 8'd4, 8'd5, 8'd6, 8'd7, 8'd0, 8'd1
	};

	localparam logic [5:0] PRG_FIXED_LAST = 6'h3F;
	localparam logic [5:0] PRG_FIXED_SECOND = 6'h3E;

	localparam int A12_LOW_SAMPLES = 4;

	localparam logic [7:0] EX_TABLE [4] = '{8'h00, 8'h02, 8'h02, 8'h03};
	localparam logic [15:0] CPU_EX_BASE = 16'h4020;
	localparam logic [2:0] RAM_AREA = 3'b011; // $6000-$7FFF

endpackage

`default_nettype wire

// File: design/mmc_reg_decode.sv
`timescale 1ns/100ps
`default_nettype none

module mmc_reg_decode import mapper_pkg::*;
(
	input  wire logic        m2,
	input  wire logic        map_rst,
	input  wire logic [15:0] cpu_addr,
	input  wire logic [7:0]  cpu_dat,
	input  wire logic        cpu_we,
	input  wire logic        cfg_mir_v,
	output mmc_cfg_t         cfg,
	output slot_wr_t         slot_wr,
	output irq_cmd_t         irq_cmd,
	output logic [7:0]       latch_val,
	output logic [7:0]       ex_reg
);

	mmc_reg_e   reg_op;
	logic       mmc_we;
	logic       ex_we;
	logic [2:0] bank_sel;

	assign reg_op = mmc_reg_e'({cpu_addr[14], cpu_addr[13], cpu_addr[0]});
	assign mmc_we = cpu_we & cpu_addr[15];
	assign ex_we = cpu_we & !cpu_addr[15] & (cpu_addr >= CPU_EX_BASE); // $4020-$7FFF

	// ==============================
	// Write pulses
	// ==============================

	always_comb
	begin
		slot_wr.we = mmc_we && (reg_op == reg_bank_data);
		slot_wr.sel = bank_sel;
		slot_wr.data = cpu_dat;
	end

	always_comb
	begin
		irq_cmd = '0;
		if (mmc_we)
		begin
			case (reg_op)
				reg_irq_latch:   irq_cmd.latch_we = 1'b1;
				reg_irq_reload:  irq_cmd.reload_req = 1'b1;
				reg_irq_disable: irq_cmd.disable_ack = 1'b1;
				reg_irq_enable:  irq_cmd.enable = 1'b1;
				default:         irq_cmd = '0;
			endcase
		end
	end

	// ==============================
	// Control registers
	// ==============================

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			bank_sel <= '0;
			cfg.swap_control <= 1'b0;
			cfg.chr_invert <= 1'b0;
			cfg.mirror_mode <= cfg_mir_v;
			cfg.ram_on <= 1'b0;
			cfg.ram_we_off <= 1'b0;
		end
		else if (mmc_we)
		begin
			case (reg_op)
				reg_bank_select:
				begin
					bank_sel <= cpu_dat[2:0];
					cfg.swap_control <= cpu_dat[6];
					cfg.chr_invert <= cpu_dat[7];
				end
				reg_mirror: cfg.mirror_mode <= cpu_dat[0];
				reg_ram_cfg:
				begin
					cfg.ram_on <= cpu_dat[7];
					cfg.ram_we_off <= cpu_dat[6];
				end
				default: bank_sel <= bank_sel;
			endcase
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
			latch_val <= '0;
		else if (irq_cmd.latch_we)
			latch_val <= cpu_dat;
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
			ex_reg <= '0;
		else if (ex_we)
			ex_reg <= EX_TABLE[cpu_dat[1:0]]; // Protection read-back value
	end

	a_irq_cmd_single: assert property (@(posedge m2) disable iff (map_rst)
		$onehot0(irq_cmd))
		else $error("more than one IRQ command pulse");

endmodule

`default_nettype wire

// File: design/bank_slot.sv
`timescale 1ns/100ps
`default_nettype none

module bank_slot import mapper_pkg::*;
#(
	parameter int SLOT_IDX = 0
)
(
	input  wire logic        m2,
	input  wire logic        map_rst,
	input  wire slot_wr_t    slot_wr,
	input  wire mmc_cfg_t    cfg,
	input  wire logic [15:0] cpu_addr,
	input  wire logic [13:0] ppu_addr,
	output slot_out_t        slot_out
);

	logic [7:0] bank_q;

	always_ff @(posedge m2)
	begin
		if (map_rst)
			bank_q <= SLOT_RESET[SLOT_IDX];
		else if (slot_wr.we && (slot_wr.sel == 3'(SLOT_IDX)))
			bank_q <= slot_wr.data;
	end

	// ==============================
	// Window decode
	// ==============================

	always_comb
	begin
		slot_out.hit = 1'b0;
		slot_out.page = bank_q;
		if (SLOT_IDX < 2)
		begin
			// 2 KB CHR, low page bit from A10
			slot_out.hit = (ppu_addr[12:11] == {cfg.chr_invert, 1'(SLOT_IDX)});
			slot_out.page = {bank_q[7:1], ppu_addr[10]};
		end
		else if (SLOT_IDX < CHR_SLOT_COUNT)
		begin
			// 1 KB CHR on the opposite half
			slot_out.hit = (ppu_addr[12] == !cfg.chr_invert)
				&& (ppu_addr[11:10] == 2'(SLOT_IDX - 2));
		end
		else if (SLOT_IDX == CHR_SLOT_COUNT)
		begin
			slot_out.hit = (cpu_addr[15:13] == {1'b1, cfg.swap_control, 1'b0}); // $8000 or $C000
		end
		else
		begin
			slot_out.hit = (cpu_addr[15:13] == 3'b101); // $A000
		end
	end

endmodule

`default_nettype wire

// File: design/bank_mapper.sv
`timescale 1ns/100ps
`default_nettype none

module bank_mapper import mapper_pkg::*;
(
	input  wire logic [15:0] cpu_addr,
	input  wire logic        cpu_rw,
	input  wire logic [13:0] ppu_addr,
	input  wire mmc_cfg_t    cfg,
	input  wire slot_out_t   slot_bus [SLOT_COUNT],
	input  wire logic [7:0]  ex_reg,
	output logic [18:0]      prg_addr,
	output logic [17:0]      chr_addr,
	output logic             ciram_a10,
	output logic             ram_ce,
	output logic             ram_we,
	output logic             rom_ce,
	output logic             map_cpu_oe,
	output logic [7:0]       map_cpu_dout
);

	logic [CHR_SLOT_COUNT-1:0]            chr_hits;
	logic [SLOT_COUNT-CHR_SLOT_COUNT-1:0] prg_hits;
	logic [7:0]                           chr_page;
	logic [7:0]                           prg_page;
	logic [5:0]                           prg_bank;
	logic                                 ram_area;

	// ==============================
	// Slot merge
	// ==============================

	// Hits are exclusive, so OR-ing the gated pages picks the winner
	always_comb
	begin
		chr_page = '0;
		prg_page = '0;
		for (int i = 0; i < SLOT_COUNT; i++)
		begin
			if (i < CHR_SLOT_COUNT)
			begin
				chr_hits[i] = slot_bus[i].hit;
				chr_page = chr_page | (slot_bus[i].hit ? slot_bus[i].page : 8'h00);
			end
			else
			begin
				prg_hits[i - CHR_SLOT_COUNT] = slot_bus[i].hit;
				prg_page = prg_page | (slot_bus[i].hit ? slot_bus[i].page : 8'h00);
			end
		end
	end

	always_comb
	begin
		if (!cpu_addr[15])
			prg_bank = '0;
		else if (|prg_hits)
			prg_bank = prg_page[5:0];
		else if (cpu_addr[14:13] == 2'b11)
			prg_bank = PRG_FIXED_LAST;
		else
			prg_bank = PRG_FIXED_SECOND; // Window left free by swap_control
	end

	assign prg_addr = {prg_bank, cpu_addr[12:0]};
	assign chr_addr = {chr_page, ppu_addr[9:0]};

	// ==============================
	// Strobes
	// ==============================

	assign ciram_a10 = cfg.mirror_mode ? ppu_addr[11] : ppu_addr[10];
	assign ram_area = (cpu_addr[15:13] == RAM_AREA);
	assign ram_ce = ram_area & cfg.ram_on;
	assign ram_we = ram_ce & !cpu_rw & !cfg.ram_we_off;
	assign rom_ce = cpu_addr[15];
	assign map_cpu_oe = cpu_rw & !cpu_addr[15] & (cpu_addr >= CPU_EX_BASE);
	assign map_cpu_dout = ex_reg;

	always_comb
	begin
		a_single_hit: assert final ($onehot0(chr_hits) && $onehot0(prg_hits))
			else $error("overlapping bank slot windows");
	end

endmodule

`default_nettype wire

// File: design/irq_counter.sv
`timescale 1ns/100ps
`default_nettype none

module irq_counter import mapper_pkg::*;
(
	input  wire logic       m2,
	input  wire logic       map_rst,
	input  wire logic       ppu_a12,
	input  wire irq_cmd_t   irq_cmd,
	input  wire logic [7:0] latch_val,
	output logic            irq
);

	logic [7:0] a12_filter;
	logic       a12_rise;
	logic       reload_pend;
	logic [7:0] irq_ctr;
	logic [7:0] ctr_next;
	logic       irq_on;
	logic       irq_pend;
	logic       irq_hit;

	// ==============================
	// A12 filter
	// ==============================

	always_ff @(posedge m2)
	begin
		if (map_rst)
			a12_filter <= '1; // No low history yet
		else
			a12_filter <= {a12_filter[6:0], ppu_a12};
	end

	assign a12_rise = ppu_a12 && (a12_filter[A12_LOW_SAMPLES-1:0] == '0);

	// ==============================
	// Counter
	// ==============================

	assign ctr_next = (reload_pend || irq_ctr == 8'd0) ? latch_val : irq_ctr - 8'd1;
	assign irq_hit = a12_rise && irq_on && (ctr_next == 8'd0);

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			irq_ctr <= '0;
			reload_pend <= 1'b0;
		end
		else
		begin
			if (a12_rise)
				irq_ctr <= ctr_next;
			if (irq_cmd.reload_req)
				reload_pend <= 1'b1; // New request beats a same-edge reload
			else if (a12_rise)
				reload_pend <= 1'b0;
		end
	end

	always_ff @(posedge m2)
	begin
		if (map_rst)
		begin
			irq_on <= 1'b0;
			irq_pend <= 1'b0;
		end
		else if (irq_cmd.disable_ack)
		begin
			irq_on <= 1'b0;
			irq_pend <= 1'b0;
		end
		else
		begin
			if (irq_cmd.enable)
				irq_on <= 1'b1;
			if (irq_hit)
				irq_pend <= 1'b1; // Held until disabled
		end
	end

	assign irq = irq_pend;

	a_irq_needs_enable: assert property (@(posedge m2) disable iff (map_rst)
		$rose(irq) |-> $past(irq_on))
		else $error("irq rose while disabled");

endmodule

`default_nettype wire

// File: design/map_238_top.sv
`timescale 1ns/100ps
`default_nettype none

module map_238_top import mapper_pkg::*;
(
	input  wire logic        m2,
	input  wire logic        map_rst,
	input  wire logic [15:0] cpu_addr,
	input  wire logic [7:0]  cpu_dat,
	input  wire logic        cpu_rw,
	input  wire logic        cpu_we,
	input  wire logic [13:0] ppu_addr,
	input  wire logic        cfg_mir_v,
	output logic [18:0]      prg_addr,
	output logic [17:0]      chr_addr,
	output logic             ciram_a10,
	output logic             ram_ce,
	output logic             ram_we,
	output logic             rom_ce,
	output logic             map_cpu_oe,
	output logic [7:0]       map_cpu_dout,
	output logic             irq
);

	mmc_cfg_t   cfg;
	slot_wr_t   slot_wr;
	irq_cmd_t   irq_cmd;
	logic [7:0] latch_val;
	logic [7:0] ex_reg;
	slot_out_t  slot_bus [SLOT_COUNT];

	// ==============================
	// Register decode
	// ==============================

	mmc_reg_decode mmc_reg_decode_inst (
		.m2        (m2),
		.map_rst   (map_rst),
		.cpu_addr  (cpu_addr),
		.cpu_dat   (cpu_dat),
		.cpu_we    (cpu_we),
		.cfg_mir_v (cfg_mir_v),
		.cfg       (cfg),
		.slot_wr   (slot_wr),
		.irq_cmd   (irq_cmd),
		.latch_val (latch_val),
		.ex_reg    (ex_reg)
	);

	for (genvar slot_idx = 0; slot_idx < SLOT_COUNT; slot_idx++)
	begin : g_slot
		bank_slot #(.SLOT_IDX(slot_idx)) bank_slot_inst (
			.m2       (m2),
			.map_rst  (map_rst),
			.slot_wr  (slot_wr),
			.cfg      (cfg),
			.cpu_addr (cpu_addr),
			.ppu_addr (ppu_addr),
			.slot_out (slot_bus[slot_idx])
		);
	end

	// ==============================
	// Translation and IRQ
	// ==============================

	bank_mapper bank_mapper_inst (
		.cpu_addr     (cpu_addr),
		.cpu_rw       (cpu_rw),
		.ppu_addr     (ppu_addr),
		.cfg          (cfg),
		.slot_bus     (slot_bus),
		.ex_reg       (ex_reg),
		.prg_addr     (prg_addr),
		.chr_addr     (chr_addr),
		.ciram_a10    (ciram_a10),
		.ram_ce       (ram_ce),
		.ram_we       (ram_we),
		.rom_ce       (rom_ce),
		.map_cpu_oe   (map_cpu_oe),
		.map_cpu_dout (map_cpu_dout)
	);

	irq_counter irq_counter_inst (
		.m2        (m2),
		.map_rst   (map_rst),
		.ppu_a12   (ppu_addr[12]),
		.irq_cmd   (irq_cmd),
		.latch_val (latch_val),
		.irq       (irq)
	);

endmodule

`default_nettype wire

// File: verification/tb_map_238.sv
`timescale 1ns/100ps
`default_nettype none

module tb_map_238 import mapper_pkg::*;
();

	logic        m2;
	logic        map_rst;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dat;
	logic        cpu_rw;
	logic        cpu_we;
	logic [13:0] ppu_addr;
	logic        cfg_mir_v;
	logic [18:0] prg_addr;
	logic [17:0] chr_addr;
	logic        ciram_a10;
	logic        ram_ce;
	logic        ram_we;
	logic        rom_ce;
	logic        map_cpu_oe;
	logic [7:0]  map_cpu_dout;
	logic        irq;

	// Reference model state
	logic [7:0] m_bank [SLOT_COUNT];
	logic [2:0] m_sel;
	logic       m_swap;
	logic       m_inv;
	logic       m_mirror;
	logic       m_ram_on;
	logic       m_we_off;
	logic [7:0] m_ex;
	logic [7:0] m_latch;
	logic [7:0] m_ctr;
	logic       m_reload;
	logic       m_irq_on;
	logic       m_irq;
	int         irq_n;
	int         pulse_cnt;

	map_238_top map_238_top_inst (
		.m2           (m2),
		.map_rst      (map_rst),
		.cpu_addr     (cpu_addr),
		.cpu_dat      (cpu_dat),
		.cpu_rw       (cpu_rw),
		.cpu_we       (cpu_we),
		.ppu_addr     (ppu_addr),
		.cfg_mir_v    (cfg_mir_v),
		.prg_addr     (prg_addr),
		.chr_addr     (chr_addr),
		.ciram_a10    (ciram_a10),
		.ram_ce       (ram_ce),
		.ram_we       (ram_we),
		.rom_ce       (rom_ce),
		.map_cpu_oe   (map_cpu_oe),
		.map_cpu_dout (map_cpu_dout),
		.irq          (irq)
	);

	initial
	begin
		m2 = 1'b0;
		forever #4 m2 = ~m2;
	end

	// ==============================
	// Reference model
	// ==============================

	function automatic logic [18:0] exp_prg(input logic [15:0] a);
		logic [5:0] bank;
		if (!a[15])
			bank = 6'h00;
		else
		begin
			case (a[14:13])
				2'b00: bank = m_swap ? PRG_FIXED_SECOND : m_bank[6][5:0];
				2'b01: bank = m_bank[7][5:0];
				2'b10: bank = m_swap ? m_bank[6][5:0] : PRG_FIXED_SECOND;
				default: bank = PRG_FIXED_LAST;
			endcase
		end
		return {bank, a[12:0]};
	endfunction

	function automatic logic [17:0] exp_chr(input logic [13:0] p);
		logic [12:0] rel;
		logic [7:0]  page;
		rel = p[12:0] ^ {m_inv, 12'h000}; // Inversion swaps the pattern table halves
		if (!rel[12])
		begin
			page = rel[11] ? m_bank[1] : m_bank[0];
			page = {page[7:1], p[10]};
		end
		else
			page = m_bank[{1'b0, rel[11:10]} + 3'd2];
		return {page, p[9:0]};
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr[15])
		begin
			case ({addr[14:13], addr[0]})
				3'b000:
				begin
					m_sel = data[2:0];
					m_swap = data[6];
					m_inv = data[7];
				end
				3'b001: m_bank[m_sel] = data;
				3'b010: m_mirror = data[0];
				3'b011:
				begin
					m_ram_on = data[7];
					m_we_off = data[6];
				end
				3'b100: m_latch = data;
				3'b101: m_reload = 1'b1;
				3'b110:
				begin
					m_irq_on = 1'b0;
					m_irq = 1'b0;
				end
				default: m_irq_on = 1'b1;
			endcase
		end
		else if (addr >= 16'h4020)
			m_ex = EX_TABLE[data[1:0]];
	endtask

	task automatic count_a12_edge();
		if (m_reload || m_ctr == 8'd0)
			m_ctr = m_latch;
		else
			m_ctr = m_ctr - 8'd1;
		m_reload = 1'b0;
		if (m_irq_on && m_ctr == 8'd0)
			m_irq = 1'b1;
	endtask

	// ==============================
	// Reporting and stimulus
	// ==============================

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp)
		else
			abort_run($sformatf("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp));
	endtask

	task automatic next_cycle();
		@(posedge m2);
		#1;
	endtask

	task automatic apply_reset(input logic mir);
		next_cycle();
		map_rst = 1'b1;
		cfg_mir_v = mir;
		cpu_we = 1'b0;
		cpu_rw = 1'b1;
		ppu_addr = 14'h0000;
		next_cycle();
		next_cycle();
		map_rst = 1'b0;
		for (int i = 0; i < SLOT_COUNT; i++)
			m_bank[i] = SLOT_RESET[i];
		{m_sel, m_swap, m_inv, m_ram_on, m_we_off} = '0;
		m_mirror = mir;
		{m_ex, m_latch, m_ctr} = '0;
		{m_reload, m_irq_on, m_irq} = '0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		next_cycle();
		cpu_addr = addr;
		cpu_dat = data;
		cpu_rw = 1'b0;
		cpu_we = 1'b1;
		next_cycle(); // Write sampled here
		cpu_we = 1'b0;
		cpu_rw = 1'b1;
		model_write(addr, data);
	endtask

	task automatic check_cpu(input logic [15:0] addr, input logic rw);
		logic ram_area;
		logic oe_exp;
		next_cycle();
		cpu_addr = addr;
		cpu_rw = rw;
		cpu_we = 1'b0;
		ram_area = (addr[15:13] == 3'b011);
		oe_exp = rw && !addr[15] && (addr >= 16'h4020);
		#2;
		check_val("prg_addr", 32'(prg_addr), 32'(exp_prg(addr)));
		check_val("ram_ce", 32'(ram_ce), 32'(ram_area && m_ram_on));
		check_val("ram_we", 32'(ram_we), 32'(ram_area && m_ram_on && !rw && !m_we_off));
		check_val("map_cpu_oe", 32'(map_cpu_oe), 32'(oe_exp));
		if (oe_exp)
			check_val("map_cpu_dout", 32'(map_cpu_dout), 32'(m_ex));
	endtask

	task automatic check_chr(input logic [13:0] paddr);
		next_cycle();
		ppu_addr = paddr;
		#2;
		check_val("chr_addr", 32'(chr_addr), 32'(exp_chr(paddr)));
		check_val("ciram_a10", 32'(ciram_a10), 32'(m_mirror ? paddr[11] : paddr[10]));
	endtask

	task automatic sweep_windows();
		for (int w = 0; w < 8; w++)
			check_chr({1'($urandom), 3'(w), 10'($urandom)});
		for (int w = 0; w < 4; w++)
			check_cpu({1'b1, 2'(w), 13'($urandom)}, 1'b1);
		check_cpu({3'b011, 13'($urandom)}, 1'b1);
		ppu_addr = 14'h0000;
	endtask

	task automatic probe_cpu_space(input logic rw);
		check_cpu(16'h401F, rw);
		check_cpu(16'h4020, rw);
		check_cpu(16'h5FFF, rw);
		check_cpu(16'h6000, rw);
		check_cpu({3'b011, 13'($urandom)}, rw);
		check_cpu(16'h7FFF, rw);
		check_cpu({1'b1, 15'($urandom)}, rw);
	endtask

	// Expects A12 low on entry; short pulses only right after another pulse
	task automatic a12_pulse(input int lows);
		for (int i = 1; i < lows; i++)
			next_cycle();
		next_cycle();
		ppu_addr = 14'h1000;
		next_cycle(); // Edge that sees A12 high
		ppu_addr = 14'h0000;
		if (lows >= A12_LOW_SAMPLES)
			count_a12_edge();
		#2;
		check_val("irq", 32'(irq), 32'(m_irq));
	endtask

	task automatic pulse_until_irq(input int limit, output int pulses);
		pulses = 0;
		while (irq !== 1'b1 && pulses < limit)
		begin
			a12_pulse(A12_LOW_SAMPLES);
			pulses++;
		end
		if (irq !== 1'b1)
			abort_run($sformatf("irq still low after %0d qualifying A12 pulses", limit));
	endtask

	// ==============================
	// Concurrent checks
	// ==============================

	a_rom_ce: assert property (@(posedge m2) disable iff (map_rst) rom_ce == cpu_addr[15])
		else abort_run($sformatf("** Error: rom_ce = 0x%0h, expected 0x%0h",
			$sampled(rom_ce), $sampled(cpu_addr[15])));

	a_ciram: assert property (@(posedge m2) disable iff (map_rst)
		ciram_a10 == (m_mirror ? ppu_addr[11] : ppu_addr[10]))
		else abort_run($sformatf("** Error: ciram_a10 = 0x%0h, mirror 0x%0h",
			$sampled(ciram_a10), $sampled(m_mirror)));

	a_ex_dout: assert property (@(posedge m2) disable iff (map_rst)
		map_cpu_oe |-> map_cpu_dout == m_ex)
		else abort_run($sformatf("** Error: map_cpu_dout = 0x%0h, expected 0x%0h",
			$sampled(map_cpu_dout), $sampled(m_ex)));

	a_irq: assert property (@(posedge m2) disable iff (map_rst) irq == m_irq)
		else abort_run($sformatf("** Error: irq = 0x%0h, expected 0x%0h",
			$sampled(irq), $sampled(m_irq)));

	initial
	begin
		for (int c = 0; c < 20000; c++)
			@(posedge m2);
		abort_run("simulation did not finish within 20000 cycles");
	end

	// ==============================
	// Main sequence
	// ==============================

	initial
	begin
		map_rst = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dat = 8'h00;
		cpu_rw = 1'b1;
		cpu_we = 1'b0;
		ppu_addr = 14'h0000;
		cfg_mir_v = 1'b0;
		void'($urandom(32'h19376f6a));

		apply_reset(1'b0);
		#2;
		check_val("irq", 32'(irq), 32'h0);
		check_val("ram_ce", 32'(ram_ce), 32'h0);
		check_val("map_cpu_oe", 32'(map_cpu_oe), 32'h0);
		sweep_windows(); // Reset banks

		for (int mode = 0; mode < 4; mode++)
		begin
			for (int k = 0; k < 8; k++)
			begin
				cpu_write({3'b100, 12'($urandom), 1'b0}, {2'(mode), 3'b000, 3'(k)});
				cpu_write({3'b100, 12'($urandom), 1'b1}, 8'($urandom));
				sweep_windows();
			end
		end

		// Ends on horizontal off so the reset below must set it
		for (int k = 0; k < 4; k++)
		begin
			cpu_write({3'b101, 12'($urandom), 1'b0}, {7'($urandom), 1'(~k)});
			for (int j = 0; j < 4; j++)
				check_chr(14'($urandom));
		end
		apply_reset(1'b1); // Mirroring reset value from cfg_mir_v
		for (int j = 0; j < 4; j++)
			check_chr(14'($urandom));

		for (int mode = 0; mode < 4; mode++)
		begin
			cpu_write({3'b101, 12'($urandom), 1'b1}, {2'(mode), 6'($urandom)});
			cpu_write(16'h4020 + 16'($urandom % 32'h3FE0), 8'($urandom));
			probe_cpu_space(1'b1);
			probe_cpu_space(1'b0);
		end

		apply_reset(1'b0);
		irq_n = 1 + int'($urandom % 12);
		cpu_write(16'hC000, 8'(irq_n));
		cpu_write(16'hC001, 8'($urandom));
		cpu_write(16'hE001, 8'($urandom));
		for (int p = 1; p <= irq_n + 1; p++)
		begin
			a12_pulse(A12_LOW_SAMPLES + int'($urandom % 3));
			check_val("irq", 32'(irq), 32'(p == irq_n + 1));
		end
		cpu_write(16'hE000, 8'($urandom));
		#2;
		check_val("irq", 32'(irq), 32'h0);

		cpu_write(16'hC000, 8'h02);
		cpu_write(16'hC001, 8'h00);
		cpu_write(16'hE001, 8'h00);
		a12_pulse(A12_LOW_SAMPLES); // Reload to 2
		a12_pulse(2);
		a12_pulse(3);
		pulse_until_irq(8, pulse_cnt);
		check_val("irq pulse count", 32'(pulse_cnt), 32'd2);

		cpu_write(16'hE000, 8'h00);
		cpu_write(16'hC000, 8'h00);
		cpu_write(16'hC001, 8'h00);
		for (int k = 0; k < 3; k++)
		begin
			cpu_write(16'hE001, 8'h00);
			a12_pulse(A12_LOW_SAMPLES);
			check_val("irq", 32'(irq), 32'h1);
			cpu_write(16'hE000, 8'h00);
			#2;
			check_val("irq", 32'(irq), 32'h0);
		end

		$display("Test OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
design/mapper_pkg.sv
design/mmc_reg_decode.sv
design/bank_slot.sv
design/bank_mapper.sv
design/irq_counter.sv
design/map_238_top.sv
verification/tb_map_238.sv

// File: Makefile
TOP = tb_map_238

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -o $(TOP)
	out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
